//--- hdl/alu.sv
`timescale 1ns/10ps

module alu (
    input  mips_pkg::alu_op_t alu_op,
    input  mips_pkg::word_t   op_a,
    input  mips_pkg::word_t   op_b,
    input  mips_pkg::shamt_t  shamt,
    input  mips_pkg::word_t   hi,
    input  mips_pkg::word_t   lo,
    output mips_pkg::word_t   result,
    output logic              zero,
    output logic              positive,
    output logic              negative,
    output logic              branch_taken
);
    import mips_pkg::*;

    logic  cmp_en;
    word_t cmp_b;

    // ----------------------------------------
    // Result
    // ----------------------------------------
    always_comb begin
        case (alu_op)
            OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU,
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
            OP_SB, OP_SH, OP_SW:      result = op_a + op_b; // Also effective address
            OP_SUB, OP_SUBU:          result = op_a - op_b;
            OP_AND, OP_ANDI:          result = op_a & op_b;
            OP_OR, OP_ORI:            result = op_a | op_b;
            OP_XOR, OP_XORI:          result = op_a ^ op_b;
            OP_NOR:                   result = ~(op_a | op_b);
            OP_SLL:                   result = op_b << shamt;
            OP_SRL:                   result = op_b >> shamt;
            OP_SRA:                   result = word_t'($signed(op_b) >>> shamt);
            OP_SLLV:                  result = op_b << op_a[4:0];
            OP_SRLV:                  result = op_b >> op_a[4:0];
            OP_SRAV:                  result = word_t'($signed(op_b) >>> op_a[4:0]);
            OP_SLT, OP_SLTI:          result = {31'b0, $signed(op_a) < $signed(op_b)};
            OP_SLTU, OP_SLTIU:        result = {31'b0, op_a < op_b};
            OP_LUI:                   result = op_b << 16;
            OP_MFHI:                  result = hi;
            OP_MFLO:                  result = lo;
            default:                  result = '0;
        endcase
    end

    // ----------------------------------------
    // Compare flags and branch decision
    // ----------------------------------------
    always_comb begin
        cmp_en = 1'b1;
        cmp_b  = '0; // Single-operand branches compare against zero
        case (alu_op)
            OP_BEQ, OP_BNE:  cmp_b = op_b;
            OP_BGEZ, OP_BGEZAL, OP_BGTZ,
            OP_BLEZ, OP_BLTZ, OP_BLTZAL: cmp_b = '0;
            default:         cmp_en = 1'b0;
        endcase
    end

    assign zero     = cmp_en && (op_a == cmp_b);
    assign positive = cmp_en && ($signed(op_a) > $signed(cmp_b));
    assign negative = cmp_en && ($signed(op_a) < $signed(cmp_b));

    always_comb begin
        case (alu_op)
            OP_BEQ:                branch_taken = zero;
            OP_BNE:                branch_taken = ~zero;
            OP_BGEZ, OP_BGEZAL:    branch_taken = ~negative;
            OP_BGTZ:               branch_taken = positive;
            OP_BLEZ:               branch_taken = ~positive;
            OP_BLTZ, OP_BLTZAL:    branch_taken = negative;
            default:               branch_taken = 1'b0;
        endcase
    end

endmodule

//--- hdl/exec_sequencer.sv
`timescale 1ns/10ps

module exec_sequencer (
    input  logic clk,
    input  logic reset,
    input  logic accept,
    output logic ready,
    output logic exec1,
    output logic exec2,
    output logic done
);
    import mips_pkg::*;

    exec_state_t state;
    exec_state_t state_next;

    always_comb begin
        case (state)
            FETCH:   state_next = accept ? EXEC1 : FETCH;
            EXEC1:   state_next = EXEC2;
            EXEC2:   state_next = FETCH;
            default: state_next = FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            state <= state_next;
        end
    end

    // Phase strobes decoded straight from the state
    assign ready = (state == FETCH);
    assign exec1 = (state == EXEC1);
    assign exec2 = (state == EXEC2);
    assign done  = exec2; // One-cycle pulse in the cycle the results are valid

endmodule

//--- hdl/hi_lo_unit.sv
`timescale 1ns/10ps

module hi_lo_unit (
    input  logic              clk,
    input  logic              reset,
    input  logic              exec1,
    input  mips_pkg::alu_op_t alu_op,
    input  mips_pkg::word_t   op_a,
    input  mips_pkg::word_t   op_b,
    output mips_pkg::word_t   hi,
    output mips_pkg::word_t   lo
);
    import mips_pkg::*;

    logic signed [63:0] prod_s;
    logic [63:0]        prod_u;
    word_t              quo_s;
    word_t              rem_s;
    word_t              quo_u;
    word_t              rem_u;
    logic               div_zero;
    logic               div_ovf;

    assign prod_s   = $signed(op_a) * $signed(op_b);
    assign prod_u   = {32'h0, op_a} * {32'h0, op_b};
    assign div_zero = (op_b == '0);
    assign div_ovf  = (op_a == 32'h8000_0000) && (op_b == 32'hffff_ffff);

    // Truncating divide with the remainder taking the dividend's sign
    always_comb begin
        if (div_zero) begin
            quo_s = '0;
            rem_s = '0;
            quo_u = '0;
            rem_u = '0;
        end else begin
            quo_s = div_ovf ? 32'h8000_0000 : word_t'($signed(op_a) / $signed(op_b));
            rem_s = div_ovf ? 32'h0 : word_t'($signed(op_a) % $signed(op_b));
            quo_u = op_a / op_b;
            rem_u = op_a % op_b;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (exec1) begin
            case (alu_op)
                OP_MULT:  {hi, lo} <= prod_s;
                OP_MULTU: {hi, lo} <= prod_u;
                OP_DIV:   if (!div_zero) begin
                    lo <= quo_s;
                    hi <= rem_s;
                end
                OP_DIVU:  if (!div_zero) begin
                    lo <= quo_u;
                    hi <= rem_u;
                end
                OP_MTHI:  hi <= op_a;
                OP_MTLO:  lo <= op_a;
                default:  ;
            endcase
        end
    end

endmodule

//--- hdl/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  logic              ready,
    input  mips_pkg::instr_t  instr,
    input  mips_pkg::word_t   rs_value,
    input  mips_pkg::word_t   rt_value,
    output logic              accept,
    output mips_pkg::alu_op_t alu_op,
    output mips_pkg::word_t   op_a,
    output mips_pkg::word_t   op_b,
    output mips_pkg::shamt_t  shamt,
    output logic              illegal
);
    import mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rt_field;
    word_t      imm_sext;
    word_t      imm_zext;
    alu_op_t    dec_op;
    word_t      dec_b;

    assign accept   = start & ready;
    assign opcode   = instr[31:26];
    assign rt_field = instr[20:16];
    assign funct    = instr[5:0];
    assign imm_sext = {{16{instr[15]}}, instr[15:0]};
    assign imm_zext = {16'h0000, instr[15:0]};

    always_comb begin
        dec_op = OP_NONE;
        dec_b  = rt_value; // Register forms and branches
        case (opcode)
            OPC_SPECIAL: begin
                case (funct)
                    FN_SLL:   dec_op = OP_SLL;
                    FN_SRL:   dec_op = OP_SRL;
                    FN_SRA:   dec_op = OP_SRA;
                    FN_SLLV:  dec_op = OP_SLLV;
                    FN_SRLV:  dec_op = OP_SRLV;
                    FN_SRAV:  dec_op = OP_SRAV;
                    FN_MFHI:  dec_op = OP_MFHI;
                    FN_MTHI:  dec_op = OP_MTHI;
                    FN_MFLO:  dec_op = OP_MFLO;
                    FN_MTLO:  dec_op = OP_MTLO;
                    FN_MULT:  dec_op = OP_MULT;
                    FN_MULTU: dec_op = OP_MULTU;
                    FN_DIV:   dec_op = OP_DIV;
                    FN_DIVU:  dec_op = OP_DIVU;
                    FN_ADD:   dec_op = OP_ADD;
                    FN_ADDU:  dec_op = OP_ADDU;
                    FN_SUB:   dec_op = OP_SUB;
                    FN_SUBU:  dec_op = OP_SUBU;
                    FN_AND:   dec_op = OP_AND;
                    FN_OR:    dec_op = OP_OR;
                    FN_XOR:   dec_op = OP_XOR;
                    FN_NOR:   dec_op = OP_NOR;
                    FN_SLT:   dec_op = OP_SLT;
                    FN_SLTU:  dec_op = OP_SLTU;
                    default:  dec_op = OP_NONE;
                endcase
            end
            OPC_REGIMM: begin
                case (rt_field)
                    RT_BLTZ:   dec_op = OP_BLTZ;
                    RT_BGEZ:   dec_op = OP_BGEZ;
                    RT_BLTZAL: dec_op = OP_BLTZAL;
                    RT_BGEZAL: dec_op = OP_BGEZAL;
                    default:   dec_op = OP_NONE;
                endcase
            end
            OPC_BEQ:   dec_op = OP_BEQ;
            OPC_BNE:   dec_op = OP_BNE;
            OPC_BLEZ:  dec_op = OP_BLEZ;
            OPC_BGTZ:  dec_op = OP_BGTZ;
            OPC_ADDI:  begin dec_op = OP_ADDI;  dec_b = imm_sext; end
            OPC_ADDIU: begin dec_op = OP_ADDIU; dec_b = imm_sext; end
            OPC_SLTI:  begin dec_op = OP_SLTI;  dec_b = imm_sext; end
            OPC_SLTIU: begin dec_op = OP_SLTIU; dec_b = imm_sext; end
            OPC_ANDI:  begin dec_op = OP_ANDI;  dec_b = imm_zext; end
            OPC_ORI:   begin dec_op = OP_ORI;   dec_b = imm_zext; end
            OPC_XORI:  begin dec_op = OP_XORI;  dec_b = imm_zext; end
            OPC_LUI:   begin dec_op = OP_LUI;   dec_b = imm_zext; end
            OPC_LB:    begin dec_op = OP_LB;    dec_b = imm_sext; end
            OPC_LH:    begin dec_op = OP_LH;    dec_b = imm_sext; end
            OPC_LW:    begin dec_op = OP_LW;    dec_b = imm_sext; end
            OPC_LBU:   begin dec_op = OP_LBU;   dec_b = imm_sext; end
            OPC_LHU:   begin dec_op = OP_LHU;   dec_b = imm_sext; end
            OPC_SB:    begin dec_op = OP_SB;    dec_b = imm_sext; end
            OPC_SH:    begin dec_op = OP_SH;    dec_b = imm_sext; end
            OPC_SW:    begin dec_op = OP_SW;    dec_b = imm_sext; end
            OPC_LWL, OPC_LWR: dec_op = OP_NONE; // Unaligned loads not supported
            default:   dec_op = OP_NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_op  <= OP_NONE;
            op_a    <= '0;
            op_b    <= '0;
            shamt   <= '0;
            illegal <= 1'b0;
        end else if (accept) begin
            alu_op  <= dec_op;
            op_a    <= rs_value;
            op_b    <= dec_b;
            shamt   <= instr[10:6];
            illegal <= (dec_op == OP_NONE);
        end
    end

endmodule

//--- hdl/mips_exec.sv
`timescale 1ns/10ps

module mips_exec (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  mips_pkg::instr_t instr,
    input  mips_pkg::word_t  rs_value,
    input  mips_pkg::word_t  rt_value,
    output logic             ready,
    output logic             done,
    output mips_pkg::word_t  result,
    output logic             zero,
    output logic             positive,
    output logic             negative,
    output logic             branch_taken,
    output logic             illegal
);
    import mips_pkg::*;

    logic    accept;
    logic    exec1;
    alu_op_t alu_op;
    word_t   op_a;
    word_t   op_b;
    shamt_t  shamt;
    word_t   hi;
    word_t   lo;

    // ----------------------------------------
    // Decode and phase control
    // ----------------------------------------
    instr_decoder u_decoder (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .ready    (ready),
        .instr    (instr),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .accept   (accept),
        .alu_op   (alu_op),
        .op_a     (op_a),
        .op_b     (op_b),
        .shamt    (shamt),
        .illegal  (illegal)
    );

    exec_sequencer u_sequencer (
        .clk    (clk),
        .reset  (reset),
        .accept (accept),
        .ready  (ready),
        .exec1  (exec1),
        .exec2  (),
        .done   (done)
    );

    // ----------------------------------------
    // Datapath
    // ----------------------------------------
    hi_lo_unit u_hi_lo (
        .clk    (clk),
        .reset  (reset),
        .exec1  (exec1),
        .alu_op (alu_op),
        .op_a   (op_a),
        .op_b   (op_b),
        .hi     (hi),
        .lo     (lo)
    );

    alu u_alu (
        .alu_op       (alu_op),
        .op_a         (op_a),
        .op_b         (op_b),
        .shamt        (shamt),
        .hi           (hi),
        .lo           (lo),
        .result       (result),
        .zero         (zero),
        .positive     (positive),
        .negative     (negative),
        .branch_taken (branch_taken)
    );

endmodule

//--- hdl/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  shamt_t;

    // Execute unit operations with the core's decode numbering
    typedef enum logic [6:0] {
        OP_NONE   = 7'd0,
        OP_ADD    = 7'd1,  OP_ADDI   = 7'd2,  OP_ADDIU  = 7'd3,  OP_ADDU   = 7'd4,
        OP_AND    = 7'd5,  OP_ANDI   = 7'd6,  OP_DIV    = 7'd7,  OP_DIVU   = 7'd8,
        OP_MFHI   = 7'd9,  OP_MFLO   = 7'd10, OP_MTHI   = 7'd11, OP_MTLO   = 7'd12,
        OP_MULT   = 7'd13, OP_MULTU  = 7'd14, OP_OR     = 7'd15, OP_ORI    = 7'd16,
        OP_SLL    = 7'd17, OP_SLLV   = 7'd18, OP_SLT    = 7'd19, OP_SLTI   = 7'd20,
        OP_SLTIU  = 7'd21, OP_SLTU   = 7'd22, OP_SRA    = 7'd23, OP_SRAV   = 7'd24,
        OP_SRL    = 7'd25, OP_SRLV   = 7'd26, OP_SUBU   = 7'd27, OP_XOR    = 7'd28,
        OP_XORI   = 7'd29,
        OP_BEQ    = 7'd30, OP_BGEZ   = 7'd31, OP_BGEZAL = 7'd32, OP_BGTZ   = 7'd33,
        OP_BLEZ   = 7'd34, OP_BLTZ   = 7'd35, OP_BLTZAL = 7'd36, OP_BNE    = 7'd37,
        OP_LB     = 7'd42, OP_LBU    = 7'd43, OP_LH     = 7'd44, OP_LHU    = 7'd45,
        OP_LUI    = 7'd46, OP_LW     = 7'd47,
        OP_SB     = 7'd50, OP_SH     = 7'd51, OP_SW     = 7'd52,
        OP_NOR    = 7'd53, OP_SUB    = 7'd54
    } alu_op_t;

    typedef enum logic [1:0] {
        FETCH,
        EXEC1,
        EXEC2
    } exec_state_t;

    // ----------------------------------------
    // Primary opcodes
    // ----------------------------------------
    localparam logic [5:0] OPC_SPECIAL = 6'h00, OPC_REGIMM = 6'h01;
    localparam logic [5:0] OPC_BEQ     = 6'h04, OPC_BNE    = 6'h05;
    localparam logic [5:0] OPC_BLEZ    = 6'h06, OPC_BGTZ   = 6'h07;
    localparam logic [5:0] OPC_ADDI    = 6'h08, OPC_ADDIU  = 6'h09;
    localparam logic [5:0] OPC_SLTI    = 6'h0a, OPC_SLTIU  = 6'h0b;
    localparam logic [5:0] OPC_ANDI    = 6'h0c, OPC_ORI    = 6'h0d;
    localparam logic [5:0] OPC_XORI    = 6'h0e, OPC_LUI    = 6'h0f;
    localparam logic [5:0] OPC_LB      = 6'h20, OPC_LH     = 6'h21;
    localparam logic [5:0] OPC_LWL     = 6'h22, OPC_LW     = 6'h23;
    localparam logic [5:0] OPC_LBU     = 6'h24, OPC_LHU    = 6'h25;
    localparam logic [5:0] OPC_LWR     = 6'h26;
    localparam logic [5:0] OPC_SB      = 6'h28, OPC_SH     = 6'h29;
    localparam logic [5:0] OPC_SW      = 6'h2b;

    // ----------------------------------------
    // SPECIAL funct codes
    // ----------------------------------------
    localparam logic [5:0] FN_SLL  = 6'h00, FN_SRL   = 6'h02, FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04, FN_SRLV  = 6'h06, FN_SRAV = 6'h07;
    localparam logic [5:0] FN_MFHI = 6'h10, FN_MTHI  = 6'h11;
    localparam logic [5:0] FN_MFLO = 6'h12, FN_MTLO  = 6'h13;
    localparam logic [5:0] FN_MULT = 6'h18, FN_MULTU = 6'h19;
    localparam logic [5:0] FN_DIV  = 6'h1a, FN_DIVU  = 6'h1b;
    localparam logic [5:0] FN_ADD  = 6'h20, FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22, FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24, FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26, FN_NOR   = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a, FN_SLTU  = 6'h2b;

    // REGIMM branches are selected by the rt field
    localparam logic [4:0] RT_BLTZ   = 5'h00, RT_BGEZ   = 5'h01;
    localparam logic [4:0] RT_BLTZAL = 5'h10, RT_BGEZAL = 5'h11;

endpackage

//--- run_sim.sh
#!/bin/sh
# Build and run the execute unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -j 0 \
    -f verilog.f --top-module mips_exec_tb \
    --Mdir obj_dir -o mips_exec_tb

./obj_dir/mips_exec_tb | tee sim.log

if grep -q "All checks passed" sim.log; then
    echo "Simulation result: PASS"
else
    echo "Simulation result: FAIL"
    exit 1
fi

//--- sim/mips_exec_tb.sv
`timescale 1ns/10ps

module mips_exec_tb;
    import mips_pkg::*;

    localparam int MAX_ENTRIES = 160;
    localparam int N_RANDOM    = 50;
    localparam logic [5:0] RAND_FUNCTS [24] = '{
        FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
        FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV,
        FN_MULT, FN_MULTU, FN_DIV, FN_DIVU, FN_MTHI, FN_MTLO, FN_MFHI, FN_MFLO
    };

    logic   clk;
    logic   reset;
    logic   start;
    instr_t instr;
    word_t  rs_value;
    word_t  rt_value;
    logic   ready;
    logic   done;
    word_t  result;
    logic   zero;
    logic   positive;
    logic   negative;
    logic   branch_taken;
    logic   illegal;

    // Stimulus and expected values with one row per instruction
    instr_t      t_instr [MAX_ENTRIES];
    word_t       t_rs    [MAX_ENTRIES];
    word_t       t_rt    [MAX_ENTRIES];
    word_t       t_res   [MAX_ENTRIES];
    logic [2:0]  t_flags [MAX_ENTRIES]; // {zero, positive, negative}
    logic        t_br    [MAX_ENTRIES];
    logic        t_ill   [MAX_ENTRIES];
    int          n_entries;
    logic        table_built;
    int          error_count;
    word_t       ref_hi;                // Reference HI/LO for the random rows
    word_t       ref_lo;
    logic [31:0] rng_state;

    mips_exec u_dut (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .instr        (instr),
        .rs_value     (rs_value),
        .rt_value     (rt_value),
        .ready        (ready),
        .done         (done),
        .result       (result),
        .zero         (zero),
        .positive     (positive),
        .negative     (negative),
        .branch_taken (branch_taken),
        .illegal      (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------
    // Instruction builders and reference model
    // ----------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic instr_t r_type(input logic [5:0] funct, input shamt_t sa);
        return {OPC_SPECIAL, 5'd1, 5'd2, 5'd3, sa, funct};
    endfunction

    function automatic instr_t i_type(input logic [5:0] opc, input logic [15:0] imm);
        return {opc, 5'd1, 5'd2, imm};
    endfunction

    function automatic instr_t regimm(input logic [4:0] rt_sel);
        return {OPC_REGIMM, 5'd1, rt_sel, 16'h0010};
    endfunction

    function automatic word_t shift_right_arith(input word_t b, input shamt_t s);
        return b[31] ? ~(~b >> s) : (b >> s); // Fill with copies of the sign bit
    endfunction

    task automatic signed_divide(input word_t a, input word_t b,
                                 output word_t q, output word_t r);
        word_t mag_a;
        word_t mag_b;
        mag_a = a[31] ? -a : a;
        mag_b = b[31] ? -b : b;
        q = mag_a / mag_b;
        r = mag_a % mag_b;
        if (a[31] != b[31]) q = -q;
        if (a[31]) r = -r; // Remainder follows the dividend
    endtask

    task automatic add_entry(input instr_t ins, input word_t a, input word_t b,
                             input word_t res, input logic [2:0] flags,
                             input logic br, input logic ill);
        t_instr[n_entries] = ins;
        t_rs[n_entries]    = a;
        t_rt[n_entries]    = b;
        t_res[n_entries]   = res;
        t_flags[n_entries] = flags;
        t_br[n_entries]    = br;
        t_ill[n_entries]   = ill;
        n_entries++;
    endtask

    task automatic add_alu(input instr_t ins, input word_t a, input word_t b, input word_t res);
        add_entry(ins, a, b, res, 3'b000, 1'b0, 1'b0);
    endtask

    task automatic add_random_rtype();
        int                 k;
        logic [5:0]         fn;
        shamt_t             sa;
        word_t              a;
        word_t              b;
        word_t              res;
        word_t              q;
        word_t              r;
        logic signed [63:0] prod;
        rng_state = xorshift32(rng_state);
        k  = int'(rng_state % 32'd24);
        fn = RAND_FUNCTS[k];
        sa = rng_state[10:6];
        rng_state = xorshift32(rng_state);
        a = rng_state;
        rng_state = xorshift32(rng_state);
        b = rng_state;
        res = '0;
        case (fn)
            FN_ADD, FN_ADDU: res = a + b;
            FN_SUB, FN_SUBU: res = a - b;
            FN_AND:   res = a & b;
            FN_OR:    res = a | b;
            FN_XOR:   res = a ^ b;
            FN_NOR:   res = ~(a | b);
            FN_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FN_SLTU:  res = (a < b) ? 32'd1 : 32'd0;
            FN_SLL:   res = b << sa;
            FN_SRL:   res = b >> sa;
            FN_SRA:   res = shift_right_arith(b, sa);
            FN_SLLV:  res = b << a[4:0];
            FN_SRLV:  res = b >> a[4:0];
            FN_SRAV:  res = shift_right_arith(b, a[4:0]);
            FN_MFHI:  res = ref_hi;
            FN_MFLO:  res = ref_lo;
            FN_MTHI:  ref_hi = a;
            FN_MTLO:  ref_lo = a;
            FN_MULT: begin
                prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
                {ref_hi, ref_lo} = prod;
            end
            FN_MULTU: {ref_hi, ref_lo} = {32'h0, a} * {32'h0, b};
            FN_DIV: if (b != 32'd0) begin
                signed_divide(a, b, q, r);
                ref_lo = q;
                ref_hi = r;
            end
            FN_DIVU: if (b != 32'd0) begin
                ref_lo = a / b;
                ref_hi = a % b;
            end
            default: ;
        endcase
        add_alu(r_type(fn, sa), a, b, res);
    endtask

    // Each branch mnemonic against a negative, a zero and a positive difference
    task automatic add_branch_rows();
        word_t      vals [3];
        logic [2:0] fl;
        vals = '{32'h8000_0004, 32'h0, 32'h0000_0005};
        for (int i = 0; i < 3; i++) begin
            fl = {vals[i] == 32'd0, !vals[i][31] && vals[i] != 32'd0, vals[i][31]};
            add_entry(regimm(RT_BLTZ), vals[i], 32'h7, 32'd0, fl, fl[0], 1'b0);
            add_entry(regimm(RT_BLTZAL), vals[i], 32'h7, 32'd0, fl, fl[0], 1'b0);
            add_entry(regimm(RT_BGEZ), vals[i], 32'h7, 32'd0, fl, !fl[0], 1'b0);
            add_entry(regimm(RT_BGEZAL), vals[i], 32'h7, 32'd0, fl, !fl[0], 1'b0);
            add_entry(i_type(OPC_BGTZ, 16'h10), vals[i], 32'h7, 32'd0, fl, fl[1], 1'b0);
            add_entry(i_type(OPC_BLEZ, 16'h10), vals[i], 32'h7, 32'd0, fl, !fl[1], 1'b0);
            add_entry(i_type(OPC_BEQ, 16'h10), vals[i] + 32'd9, 32'd9, 32'd0, fl, fl[2], 1'b0);
            add_entry(i_type(OPC_BNE, 16'h10), vals[i] + 32'd9, 32'd9, 32'd0, fl, !fl[2], 1'b0);
        end
    endtask

    task automatic build_table();
        // Random rows first, while HI and LO still hold zero from reset
        for (int i = 0; i < N_RANDOM; i++) add_random_rtype();
        add_alu(r_type(FN_ADDU, 5'd0), 32'd5, 32'd7, 32'd12);
        add_alu(r_type(FN_ADD, 5'd0), 32'hffff_ffff, 32'd1, 32'd0);
        add_alu(r_type(FN_SUB, 5'd0), 32'd3, 32'd5, 32'hffff_fffe);
        add_alu(r_type(FN_AND, 5'd0), 32'hff00_ff00, 32'h0ff0_0ff0, 32'h0f00_0f00);
        add_alu(r_type(FN_OR, 5'd0), 32'hff00_ff00, 32'h0ff0_0ff0, 32'hfff0_fff0);
        add_alu(r_type(FN_XOR, 5'd0), 32'hff00_ff00, 32'h0ff0_0ff0, 32'hf0f0_f0f0);
        add_alu(r_type(FN_NOR, 5'd0), 32'hff00_ff00, 32'h0ff0_0ff0, 32'h000f_000f);
        add_alu(r_type(FN_SLL, 5'd4), 32'd0, 32'h8000_0001, 32'h0000_0010);
        add_alu(r_type(FN_SRL, 5'd4), 32'd0, 32'h8000_0001, 32'h0800_0000);
        add_alu(r_type(FN_SRA, 5'd4), 32'd0, 32'h8000_0001, 32'hf800_0000);
        add_alu(r_type(FN_SLLV, 5'd0), 32'd36, 32'd1, 32'h0000_0010);
        add_alu(r_type(FN_SRAV, 5'd0), 32'd1, 32'h8000_0000, 32'hc000_0000);
        add_alu(r_type(FN_SLT, 5'd0), 32'hffff_ffff, 32'd1, 32'd1);
        add_alu(r_type(FN_SLTU, 5'd0), 32'hffff_ffff, 32'd1, 32'd0);
        add_alu(i_type(OPC_ADDI, 16'hfffe), 32'd10, 32'd0, 32'd8);
        add_alu(i_type(OPC_ADDIU, 16'h8000), 32'd0, 32'd0, 32'hffff_8000);
        add_alu(i_type(OPC_SLTI, 16'hfffc), 32'hffff_fffb, 32'd0, 32'd1);
        add_alu(i_type(OPC_SLTIU, 16'hffff), 32'd5, 32'd0, 32'd1);
        add_alu(i_type(OPC_ANDI, 16'h8001), 32'hffff_ffff, 32'd0, 32'h0000_8001);
        add_alu(i_type(OPC_ORI, 16'h8000), 32'h1234_0000, 32'd0, 32'h1234_8000);
        add_alu(i_type(OPC_XORI, 16'hffff), 32'hffff_0000, 32'd0, 32'hffff_ffff);
        add_alu(i_type(OPC_LUI, 16'h8765), 32'h1111, 32'd0, 32'h8765_0000);
        add_alu(i_type(OPC_LW, 16'hfffc), 32'h1000, 32'd0, 32'h0000_0ffc);
        add_alu(i_type(OPC_LH, 16'h8000), 32'h0100, 32'd0, 32'hffff_8100);
        add_alu(i_type(OPC_SB, 16'h0010), 32'h2000, 32'd0, 32'h0000_2010);
        // ----------------------------------------
        // HI/LO sequences
        // ----------------------------------------
        add_alu(r_type(FN_MULT, 5'd0), 32'hffff_fffd, 32'd7, 32'd0);
        add_alu(r_type(FN_MFHI, 5'd0), 32'd0, 32'd0, 32'hffff_ffff);
        add_alu(r_type(FN_MFLO, 5'd0), 32'd0, 32'd0, 32'hffff_ffeb);
        add_alu(r_type(FN_MULTU, 5'd0), 32'hffff_ffff, 32'd2, 32'd0);
        add_alu(r_type(FN_MFHI, 5'd0), 32'd0, 32'd0, 32'h0000_0001);
        add_alu(r_type(FN_MFLO, 5'd0), 32'd0, 32'd0, 32'hffff_fffe);
        add_alu(r_type(FN_DIV, 5'd0), 32'hffff_fff9, 32'd2, 32'd0);
        add_alu(r_type(FN_MFLO, 5'd0), 32'd0, 32'd0, 32'hffff_fffd);
        add_alu(r_type(FN_MFHI, 5'd0), 32'd0, 32'd0, 32'hffff_ffff);
        add_alu(r_type(FN_DIVU, 5'd0), 32'hffff_ffff, 32'd16, 32'd0);
        add_alu(r_type(FN_DIV, 5'd0), 32'd5, 32'd0, 32'd0); // Divide by zero keeps HI/LO
        add_alu(r_type(FN_DIVU, 5'd0), 32'd9, 32'd0, 32'd0);
        add_alu(r_type(FN_MFLO, 5'd0), 32'd0, 32'd0, 32'h0fff_ffff);
        add_alu(r_type(FN_MFHI, 5'd0), 32'd0, 32'd0, 32'h0000_000f);
        add_alu(r_type(FN_DIV, 5'd0), 32'h8000_0000, 32'hffff_ffff, 32'd0);
        add_alu(r_type(FN_MFLO, 5'd0), 32'd0, 32'd0, 32'h8000_0000);
        add_alu(r_type(FN_MFHI, 5'd0), 32'd0, 32'd0, 32'd0);
        add_alu(r_type(FN_MTHI, 5'd0), 32'hcafe_0001, 32'd0, 32'd0);
        add_alu(r_type(FN_MFHI, 5'd0), 32'd0, 32'd0, 32'hcafe_0001);
        add_alu(r_type(FN_MFLO, 5'd0), 32'd0, 32'd0, 32'h8000_0000);
        add_alu(r_type(FN_MTLO, 5'd0), 32'h0bad_f00d, 32'd0, 32'd0);
        add_alu(r_type(FN_MFLO, 5'd0), 32'd0, 32'd0, 32'h0bad_f00d);
        add_alu(r_type(FN_MFHI, 5'd0), 32'd0, 32'd0, 32'hcafe_0001);
        add_branch_rows();
        add_entry(i_type(OPC_LWL, 16'h0004), 32'h1000, 32'd0, 32'd0, 3'b000, 1'b0, 1'b1);
        add_entry(i_type(OPC_LWR, 16'h0004), 32'h1000, 32'd0, 32'd0, 3'b000, 1'b0, 1'b1);
        add_entry(r_type(6'h01, 5'd0), 32'd3, 32'd4, 32'd0, 3'b000, 1'b0, 1'b1);
    endtask

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    task automatic report_failure(input string msg);
        error_count++;
        $display("FAIL at time %0t: %s", $time, msg);
        $display("Checks failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) report_failure($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_flags(input string what, input logic z, input logic p,
                               input logic n, input logic [2:0] exp);
        if ({z, p, n} !== exp)
            report_failure($sformatf("%s zpn is %b, expected %b", what, {z, p, n}, exp));
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) report_failure($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    // Starts at a falling edge and returns at the falling edge after done
    task automatic run_entry(input int idx);
        int   edges;
        logic done_seen;
        while (!ready) @(negedge clk);
        @(posedge clk);
        start    <= 1'b1;
        instr    <= t_instr[idx];
        rs_value <= t_rs[idx];
        rt_value <= t_rt[idx];
        edges     = 0;
        done_seen = 1'b0;
        while (!done_seen) begin
            @(posedge clk);
            edges++;
            if (edges == 1) begin
                instr    <= i_type(OPC_LUI, 16'hdead); // Start while busy is ignored
                rs_value <= ~t_rs[idx];
                rt_value <= ~t_rt[idx];
            end else begin
                start <= 1'b0;
            end
            @(negedge clk);
            if (done) done_seen = 1'b1;
            else check_bit($sformatf("entry %0d ready while busy", idx), ready, 1'b0);
        end
        if (edges != 2)
            report_failure($sformatf("entry %0d done after %0d edges, expected 2", idx, edges));
        check_bit($sformatf("entry %0d ready during done", idx), ready, 1'b0);
        check_word($sformatf("entry %0d result", idx), result, t_res[idx]);
        check_flags($sformatf("entry %0d flags", idx), zero, positive, negative, t_flags[idx]);
        check_bit($sformatf("entry %0d branch_taken", idx), branch_taken, t_br[idx]);
        check_bit($sformatf("entry %0d illegal", idx), illegal, t_ill[idx]);
        @(negedge clk);
        check_bit($sformatf("entry %0d done width", idx), done, 1'b0);
        check_bit($sformatf("entry %0d ready after done", idx), ready, 1'b1);
    endtask

    initial begin
        start       = 1'b0;
        instr       = '0;
        rs_value    = '0;
        rt_value    = '0;
        reset       = 1'b1;
        error_count = 0;
        n_entries   = 0;
        table_built = 1'b0;
        ref_hi      = '0;
        ref_lo      = '0;
        rng_state   = 32'h66ef_6c55;
        build_table();
        table_built = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_bit("ready after reset", ready, 1'b1);
        check_bit("done after reset", done, 1'b0);
        for (int i = 0; i < n_entries; i++) run_entry(i);
        if (error_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "errors were recorded");
        end
    end

    // Three cycles per instruction, doubled for handshake slack, plus reset
    initial begin
        int limit;
        wait (table_built);
        limit = n_entries * 3 * 2 + 100;
        repeat (limit) @(posedge clk);
        $display("Timeout: done never arrived within %0d cycles", limit);
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- verilog.f
hdl/mips_pkg.sv
hdl/instr_decoder.sv
hdl/alu.sv
hdl/hi_lo_unit.sv
hdl/exec_sequencer.sv
hdl/mips_exec.sv
sim/mips_exec_tb.sv
